// File: tb.f
rtl/ramio_pkg.sv
rtl/uart_tx.sv
rtl/bus_decode.sv
rtl/bus_execute.sv
rtl/load_format.sv
rtl/ramio.sv
verif/ramio_checker.sv
verif/tb_ramio.sv

// File: verif/tb_ramio.sv
//------------------------------------------------
// ramio testbench
// random requests with random response stalls,
// checked by the ramio checker
//------------------------------------------------
module tb_ramio;
  timeunit 1ns;
  timeprecision 1ps;
  import ramio_pkg::*;

  localparam int unsigned RAM_WORDS    = 256;
  localparam int unsigned CLKS_PER_BIT = 4;
  localparam int          NUM_REQ      = 2000;
  localparam int          WAIT_LIMIT   = 1000;

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  logic       req_ready;
  mem_req_t   req;
  logic       rsp_valid;
  logic       rsp_ready;
  mem_rsp_t   rsp;
  logic [3:0] led;
  logic       uart_tx;
  logic       drain_done;
  // request handshake seen at the last rising edge
  logic       req_taken;
  integer     seed;
  int         accepted;
  int         hang_count;
  int         mismatch_count;
  int         failure_count;
  int         outstanding;
  int         uart_pending;

  ramio #(
    .RAM_WORDS   (RAM_WORDS),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_ramio (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp),
    .led      (led),
    .uart_tx  (uart_tx)
  );

  ramio_checker #(
    .RAM_WORDS   (RAM_WORDS),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .led           (led),
    .uart_tx       (uart_tx),
    .drain_done    (drain_done),
    .mismatch_count(mismatch_count),
    .failure_count (failure_count),
    .outstanding   (outstanding),
    .uart_pending  (uart_pending)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    req_taken = req_valid && req_ready;
  end

  // fill word, every address bit matters
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic mem_req_t random_req();
    mem_req_t     r;
    int           kind;
    int           place;
    access_size_t sz;
    logic [1:0]   offs;
    r     = '0;
    kind  = $unsigned($random(seed)) % 8;
    place = $unsigned($random(seed)) % 16;
    sz    = access_size_t'(2'(1 + $unsigned($random(seed)) % 3));
    offs  = 2'($random(seed));
    // mostly aligned, a few misaligned ones
    if (($unsigned($random(seed)) % 8) != 0) begin
      if (sz == SIZE_HALF) begin
        offs[0] = 1'b0;
      end
      if (sz == SIZE_WORD) begin
        offs = 2'b00;
      end
    end
    if (place < 11) begin
      r.address = (($unsigned($random(seed)) % RAM_WORDS) << 2) | offs;
    end else if (place < 13) begin
      r.address = ADDR_LED;
    end else if (place < 15) begin
      r.address = ADDR_UART_OUT;
    end else begin
      r.address = 32'h0010_0000 | ($random(seed) & 32'h000f_fffc) | offs;
    end
    r.data        = $random(seed);
    r.read_signed = 1'($random(seed));
    // stores, loads, both sizes set, and no-ops
    if (kind <= 2 || kind == 6) begin
      r.write_size = sz;
    end
    if (kind >= 3) begin
      r.read_size = (kind == 7) ? SIZE_NONE : sz;
    end
    return r;
  endfunction

  initial begin : drive
    int stall;
    int waited;
    int idle_run;
    seed       = 31;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b0;
    drain_done = 1'b0;
    accepted   = 0;
    hang_count = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    stall = 0;
    while (accepted < NUM_REQ && hang_count == 0) begin
      @(negedge clk);
      rsp_ready = ($unsigned($random(seed)) % 4) != 0;
      if (req_valid && req_taken) begin
        accepted++;
        req_valid = 1'b0;
        stall     = 0;
      end
      if (req_valid) begin
        stall++;
        if (stall > WAIT_LIMIT) begin
          $display("timeout: request at %0t was never accepted", $time);
          hang_count++;
        end
      end else if (accepted < NUM_REQ) begin
        // fill the ram first, then a uart burst, then random traffic
        if (accepted < RAM_WORDS) begin
          req            = '0;
          req.write_size = SIZE_WORD;
          req.address    = 32'(accepted * 4);
          req.data       = fill_word(req.address);
          req_valid      = 1'b1;
        end else if (accepted < RAM_WORDS + 4) begin
          req            = '0;
          req.write_size = SIZE_BYTE;
          req.address    = ADDR_UART_OUT;
          req.data       = $random(seed);
          req_valid      = 1'b1;
        end else if (($unsigned($random(seed)) % 8) != 0) begin
          req       = random_req();
          req_valid = 1'b1;
        end
      end
    end
    // drain the responses
    waited = 0;
    while (hang_count == 0 && outstanding != 0) begin
      @(negedge clk);
      rsp_ready = ($unsigned($random(seed)) % 4) != 0;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: %0d responses still outstanding", outstanding);
        hang_count++;
      end
    end
    // let the uart finish and stay quiet for two frames
    rsp_ready = 1'b1;
    waited    = 0;
    idle_run  = 0;
    while (hang_count == 0 && (uart_pending != 0 || idle_run < 24 * CLKS_PER_BIT)) begin
      @(negedge clk);
      idle_run = (uart_tx === 1'b1) ? idle_run + 1 : 0;
      waited++;
      if (waited > 4 * WAIT_LIMIT) begin
        $display("timeout: uart line never went idle");
        hang_count++;
      end
    end
    drain_done = 1'b1;
    @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatch_count, failure_count, hang_count);
    if (mismatch_count == 0 && failure_count == 0 && hang_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verif/ramio_checker.sv
//------------------------------------------------
// ramio checker
// byte model of ram, leds and uart out, compares
// responses in order and decodes the serial line
//------------------------------------------------
module ramio_checker #(
  parameter int unsigned RAM_WORDS    = 256,
  parameter int unsigned CLKS_PER_BIT = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  logic                req_ready,
  input  ramio_pkg::mem_req_t req,
  input  logic                rsp_valid,
  input  logic                rsp_ready,
  input  ramio_pkg::mem_rsp_t rsp,
  input  logic [3:0]          led,
  input  logic                uart_tx,
  input  logic                drain_done,
  output int                  mismatch_count,
  output int                  failure_count,
  output int                  outstanding,
  output int                  uart_pending
);
  timeunit 1ns;
  timeprecision 1ps;
  import ramio_pkg::*;

  // one expected response, in request order
  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        uart_read;
    logic        uart_seen;
    logic        led_store;
  } expect_t;

  logic [7:0] ram_bytes [RAM_WORDS*4];
  logic [3:0] led_model;
  logic [7:0] uart_last;
  logic       uart_seen;
  expect_t    exp_q [$];
  // led values of stores not yet answered
  logic [3:0] led_hist [$];
  // bytes stored to uart, waiting for their frame
  logic [7:0] uart_q [$];

  initial begin
    mismatch_count = 0;
    failure_count  = 0;
    outstanding    = 0;
    uart_pending   = 0;
    led_model      = 4'b1111;
    uart_last      = 8'h00;
    uart_seen      = 1'b0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    mismatch_count++;
  endtask

  // ------------------------------------------------
  // reference model, applied at the accept edge
  // ------------------------------------------------
  task automatic apply_request(input mem_req_t r);
    expect_t      e;
    logic         wr;
    logic         rd;
    int           nbytes;
    logic [31:0]  a;
    logic [31:0]  word;
    access_size_t sz;
    e  = '0;
    a  = r.address;
    // a store wins when both sizes are set
    wr = r.write_size != SIZE_NONE;
    rd = !wr && r.read_size != SIZE_NONE;
    sz = wr ? r.write_size : r.read_size;
    nbytes = (sz == SIZE_WORD) ? 4 : (sz == SIZE_HALF) ? 2 : 1;
    e.err = (nbytes == 2 && a[0]) || (nbytes == 4 && a[1:0] != 2'b00);
    if (!e.err && a == ADDR_LED) begin
      if (wr) begin
        led_model = r.data[3:0];
        led_hist.push_back(r.data[3:0]);
        e.led_store = 1'b1;
      end else if (rd) begin
        e.data = {28'h0, led_model};
      end
    end else if (!e.err && a == ADDR_UART_OUT) begin
      if (wr) begin
        uart_last = r.data[7:0];
        uart_seen = 1'b1;
        uart_q.push_back(r.data[7:0]);
      end else if (rd) begin
        // idle reads all ones, a busy line reads its byte
        e.uart_read = 1'b1;
        e.uart_seen = uart_seen;
        e.data      = {24'h0, uart_last};
      end
    end else if (!e.err && a < RAM_WORDS * 4) begin
      word = '0;
      for (int k = 0; k < nbytes; k++) begin
        if (wr) begin
          ram_bytes[a + k] = r.data[8*k +: 8];
        end
        word[8*k +: 8] = ram_bytes[a + k];
      end
      if (rd) begin
        if (nbytes == 1 && r.read_signed) begin
          word[31:8] = {24{word[7]}};
        end
        if (nbytes == 2 && r.read_signed) begin
          word[31:16] = {16{word[15]}};
        end
        e.data = word;
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic check_response();
    expect_t    e;
    logic       data_ok;
    logic       found;
    logic [3:0] led_want;
    if (exp_q.size() == 0) begin
      $display("error at %0t: response with no request outstanding", $time);
      failure_count++;
    end else begin
      e = exp_q.pop_front();
      if (rsp.err !== e.err) begin
        report_mismatch("rsp.err", 32'(e.err), 32'(rsp.err));
      end
      if (e.uart_read) begin
        data_ok = (rsp.data === 32'hffff_ffff) || (e.uart_seen && rsp.data === e.data);
      end else begin
        data_ok = rsp.data === e.data;
      end
      if (!data_ok) begin
        report_mismatch("rsp.data", e.data, rsp.data);
      end
      // led holds this store or a later one already executed
      if (e.led_store) begin
        led_want = led_hist.pop_front();
        found    = led === led_want;
        foreach (led_hist[i]) begin
          if (led === led_hist[i]) begin
            found = 1'b1;
          end
        end
        if (!found) begin
          report_mismatch("led", 32'(led_want), 32'(led));
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n === 1'b1) begin
      if (rsp_valid && rsp_ready) begin
        check_response();
      end
      if (req_valid && req_ready) begin
        apply_request(req);
      end
      outstanding  = exp_q.size();
      uart_pending = uart_q.size();
    end
  end

  // ------------------------------------------------
  // serial receiver, samples each bit mid-way
  // ------------------------------------------------
  initial begin : uart_monitor
    logic [7:0] rx_byte;
    logic [7:0] want;
    forever begin
      @(posedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat ((CLKS_PER_BIT - 1) / 2) @(posedge clk);
        if (uart_tx !== 1'b0) begin
          $display("error at %0t: uart start bit ended early", $time);
          failure_count++;
        end
        // lsb first
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          rx_byte[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        if (uart_tx !== 1'b1) begin
          $display("error at %0t: uart frame has no stop bit", $time);
          failure_count++;
        end
        if (uart_q.size() == 0) begin
          $display("error at %0t: uart frame sent with no store behind it", $time);
          failure_count++;
        end else begin
          want = uart_q.pop_front();
          if (rx_byte !== want) begin
            report_mismatch("uart_tx byte", 32'(want), 32'(rx_byte));
          end
        end
        uart_pending = uart_q.size();
      end
    end
  end

  // end of run, nothing may be left over
  always @(posedge drain_done) begin
    if (exp_q.size() != 0) begin
      $display("error: %0d requests never got a response", exp_q.size());
      failure_count++;
    end
    if (uart_q.size() != 0) begin
      $display("error: %0d uart bytes never appeared on the line", uart_q.size());
      failure_count++;
    end
    if (led !== led_model) begin
      report_mismatch("led", 32'(led_model), 32'(led));
    end
  end

endmodule

// File: rtl/ramio.sv
//------------------------------------------------
// ramio top
// load/store port for ram, leds and uart out,
// decode, execute and result stages in a row
//------------------------------------------------
module ramio #(
  parameter int unsigned RAM_WORDS    = 256,
  parameter int unsigned CLKS_PER_BIT = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  ramio_pkg::mem_req_t req,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output ramio_pkg::mem_rsp_t rsp,
  output logic [3:0]          led,
  output logic                uart_tx
);
  import ramio_pkg::*;

  // decode to execute
  logic      op_valid;
  logic      op_ready;
  mem_op_t   op;
  // execute to result
  logic      res_valid;
  logic      res_ready;
  exec_res_t res;

  bus_decode #(
    .RAM_WORDS(RAM_WORDS)
  ) u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .op_valid (op_valid),
    .op_ready (op_ready),
    .op       (op)
  );

  bus_execute #(
    .RAM_WORDS   (RAM_WORDS),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_valid (op_valid),
    .op_ready (op_ready),
    .op       (op),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res      (res),
    .led      (led),
    .uart_tx  (uart_tx)
  );

  load_format u_format (
    .clk      (clk),
    .rst_n    (rst_n),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res      (res),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp)
  );

endmodule

// File: rtl/load_format.sv
//------------------------------------------------
// result stage
// picks the load lane, extends it and registers
// the response with its error flag
//------------------------------------------------
module load_format (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 res_valid,
  output logic                 res_ready,
  input  ramio_pkg::exec_res_t res,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output ramio_pkg::mem_rsp_t  rsp
);
  import ramio_pkg::*;

  logic        res_fire;
  // raw word moved down so the addressed lane sits at bit 0
  logic [31:0] lane;
  logic [31:0] data_fmt;

  assign res_ready = !rsp_valid || rsp_ready;
  assign res_fire  = res_valid && res_ready;

  always_comb begin
    lane     = res.raw >> {res.byte_offset, 3'b000};
    data_fmt = '0;
    // stores, faults and unmapped reads return zero
    if (res.is_read && !res.err) begin
      case (res.read_size)
        SIZE_BYTE: begin
          data_fmt = res.read_signed ? {{24{lane[7]}}, lane[7:0]} : {24'h0, lane[7:0]};
        end
        SIZE_HALF: begin
          data_fmt = res.read_signed ? {{16{lane[15]}}, lane[15:0]} : {16'h0, lane[15:0]};
        end
        SIZE_WORD: begin
          data_fmt = res.raw;
        end
        default: begin
          data_fmt = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (res_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (res_fire) begin
      rsp.data <= data_fmt;
      rsp.err  <= res.err;
    end
  end

endmodule

// File: rtl/bus_execute.sv
//------------------------------------------------
// execute stage
// word ram, led register and uart staging, runs
// the decoded op and registers the raw result
//------------------------------------------------
module bus_execute #(
  parameter int unsigned RAM_WORDS    = 256,
  parameter int unsigned CLKS_PER_BIT = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 op_valid,
  output logic                 op_ready,
  input  ramio_pkg::mem_op_t   op,
  output logic                 res_valid,
  input  logic                 res_ready,
  output ramio_pkg::exec_res_t res,
  output logic [3:0]           led,
  output logic                 uart_tx
);
  import ramio_pkg::*;

  localparam int unsigned AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] ram_idx;
  logic          op_fire;
  logic          ram_we;
  logic          led_we;
  logic          uart_we;
  logic          tx_start;
  logic          tx_busy;
  // byte on the line, all ones when idle
  logic [31:0]   uart_sending;

  assign ram_idx = op.word_index[AW-1:0];
  assign uart_we = op.target == TGT_UART_OUT && op.is_write && !op.err;

  // a uart store waits for the transmitter to drain
  assign op_ready = !(op_valid && uart_we && tx_busy) && (!res_valid || res_ready);
  assign op_fire  = op_valid && op_ready;

  // side effects only for clean ops
  assign ram_we   = op_fire && op.target == TGT_RAM && op.is_write && !op.err;
  assign led_we   = op_fire && op.target == TGT_LED && op.is_write && !op.err;
  assign tx_start = op_fire && uart_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid    <= 1'b0;
      led          <= 4'b1111;
      uart_sending <= '1;
    end else begin
      if (op_fire) begin
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
      if (led_we) begin
        led <= op.wdata[3:0];
      end
      // busy rises the edge after start, so the start cycle wins here
      if (tx_start) begin
        uart_sending <= {24'h0, op.wdata[7:0]};
      end else if (!tx_busy) begin
        uart_sending <= '1;
      end
    end
  end

  // ------------------------------------------------
  // ram and result register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (ram_we) begin
      for (int i = 0; i < 4; i++) begin
        if (op.lane_en[i]) begin
          mem[ram_idx][8*i +: 8] <= op.wdata[8*i +: 8];
        end
      end
    end
    if (op_fire) begin
      // i/o words go out whole, so they are tagged as word reads
      res.read_size   <= (op.target == TGT_RAM) ? op.read_size : SIZE_WORD;
      res.read_signed <= op.read_signed;
      res.byte_offset <= op.byte_offset;
      res.is_read     <= op.is_read;
      res.err         <= op.err;
      unique case (op.target)
        TGT_RAM:      res.raw <= mem[ram_idx];
        TGT_LED:      res.raw <= {28'h0, led};
        TGT_UART_OUT: res.raw <= uart_sending;
        TGT_NONE:     res.raw <= '0;
      endcase
    end
  end

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .clk  (clk),
    .rst_n(rst_n),
    .start(tx_start),
    .data (op.wdata[7:0]),
    .busy (tx_busy),
    .tx   (uart_tx)
  );

  // a faulting op leaves the addressed word as it was
  assert property (@(posedge clk) disable iff (!rst_n)
    op_fire && op.err |=> mem[$past(ram_idx)] == $past(mem[ram_idx]));

endmodule

// File: rtl/bus_decode.sv
//------------------------------------------------
// decode stage
// registers a request, picks its target and builds
// byte lanes, aligned store data and the error flag
//------------------------------------------------
module bus_decode #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  ramio_pkg::mem_req_t req,
  output logic                op_valid,
  input  logic                op_ready,
  output ramio_pkg::mem_op_t  op
);
  import ramio_pkg::*;

  // first byte address past the ram
  localparam logic [31:0] RAM_LIMIT = 32'(RAM_WORDS * 4);

  logic         started;
  logic         req_fire;
  access_size_t size;
  mem_op_t      op_next;

  // hold off the very first cycle out of reset
  assign req_ready = started && (!op_valid || op_ready);
  assign req_fire  = req_valid && req_ready;

  always_comb begin
    op_next = '0;
    // a store wins when both sizes are set
    op_next.is_write = req.write_size != SIZE_NONE;
    op_next.is_read  = !op_next.is_write && (req.read_size != SIZE_NONE);
    size = op_next.is_write ? req.write_size : req.read_size;

    // i/o words first, then the ram window
    if (req.address == ADDR_LED) begin
      op_next.target = TGT_LED;
    end else if (req.address == ADDR_UART_OUT) begin
      op_next.target = TGT_UART_OUT;
    end else if (req.address < RAM_LIMIT) begin
      op_next.target = TGT_RAM;
    end else begin
      op_next.target = TGT_NONE;
    end

    op_next.word_index  = req.address[31:2];
    op_next.byte_offset = req.address[1:0];
    op_next.read_size   = req.read_size;
    op_next.read_signed = req.read_signed;

    // half words on even bytes, words on word boundaries
    op_next.err = (size == SIZE_HALF && req.address[0]) ||
                  (size == SIZE_WORD && req.address[1:0] != 2'b00);

    // store lanes, data moved up to its byte offset
    if (op_next.is_write) begin
      case (req.write_size)
        SIZE_BYTE: begin
          op_next.lane_en = 4'b0001 << req.address[1:0];
          op_next.wdata   = {24'h0, req.data[7:0]} << {req.address[1:0], 3'b000};
        end
        SIZE_HALF: begin
          op_next.lane_en = 4'b0011 << req.address[1:0];
          op_next.wdata   = {16'h0, req.data[15:0]} << {req.address[1:0], 3'b000};
        end
        default: begin
          op_next.lane_en = 4'b1111;
          op_next.wdata   = req.data;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started  <= 1'b0;
      op_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (req_fire) begin
        op_valid <= 1'b1;
      end else if (op_ready) begin
        op_valid <= 1'b0;
      end
    end
  end

  // op payload
  always_ff @(posedge clk) begin
    if (req_fire) begin
      op <= op_next;
    end
  end

  // execute may stall, the op must not move under it
  assert property (@(posedge clk) disable iff (!rst_n)
    op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

// File: rtl/uart_tx.sv
//------------------------------------------------
// uart transmitter
// 8n1 frames, lsb first, CLKS_PER_BIT clocks a bit
//------------------------------------------------
module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);

  localparam int unsigned CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  // stop, data, start with the start bit at the bottom
  logic [9:0]    shreg;
  logic [3:0]    bit_cnt;
  logic [CW-1:0] clk_cnt;

  // line idles high
  assign tx = busy ? shreg[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        clk_cnt <= '0;
      end
    end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      // last clock of the stop bit ends the frame
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + CW'(1);
    end
  end

  // frame shifter
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shreg <= {1'b1, data, 1'b0};
    end else if (busy && clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

  // the caller has to wait out the whole frame
  assert property (@(posedge clk) disable iff (!rst_n) busy |-> !start);

endmodule

// File: rtl/ramio_pkg.sv
//------------------------------------------------
// ramio package
// access sizes, address map and the structs that
// flow between the load/store port stages
//------------------------------------------------
package ramio_pkg;

  // access width of a load or store
  typedef enum logic [1:0] {
    SIZE_NONE = 2'd0,
    SIZE_BYTE = 2'd1,
    SIZE_HALF = 2'd2,
    SIZE_WORD = 2'd3
  } access_size_t;

  // where a decoded request is served
  typedef enum logic [1:0] {
    TGT_RAM      = 2'd0,
    TGT_LED      = 2'd1,
    TGT_UART_OUT = 2'd2,
    TGT_NONE     = 2'd3
  } target_t;

  // ------------------------------------------------
  // i/o map, word addresses at the top of the space
  // ------------------------------------------------
  // led nibble, 0 is led on
  localparam logic [31:0] ADDR_LED      = 32'hffff_fffc;
  // uart out, reads all ones when idle
  localparam logic [31:0] ADDR_UART_OUT = 32'hffff_fff8;

  // request from the processor
  typedef struct packed {
    access_size_t read_size;
    logic         read_signed;
    access_size_t write_size;
    logic [31:0]  address;
    logic [31:0]  data;
  } mem_req_t;

  // decode to execute
  typedef struct packed {
    target_t      target;
    logic         is_read;
    logic         is_write;
    logic [29:0]  word_index;
    logic [3:0]   lane_en;
    logic [31:0]  wdata;
    access_size_t read_size;
    logic         read_signed;
    logic [1:0]   byte_offset;
    logic         err;
  } mem_op_t;

  // execute to result
  typedef struct packed {
    logic [31:0]  raw;
    access_size_t read_size;
    logic         read_signed;
    logic [1:0]   byte_offset;
    logic         is_read;
    logic         err;
  } exec_res_t;

  // response to the processor
  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } mem_rsp_t;

endpackage
